// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := sampler_tb
FILELIST   := sampler.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) verif/sampler_tb_model.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/rej_sampler.sv ====
// rejection sampler that writes beats below q as coefficients upward from a base address
module rej_sampler (
  input  logic                            clk,
  input  logic                            rst_b,
  input  logic                            zeroize_i,
  input  logic                            start_i,
  input  logic                            ent_valid_i,
  input  sampler_field_pkg::ent_word_t    ent_data_i,
  input  sampler_field_pkg::mem_addr_t    dest_base_addr_i,
  output logic                            ent_hold_o,
  output sampler_ctrl_pkg::coeff_wr_t     mem_wr_o,
  output logic                            done_o
);
  import sampler_field_pkg::*;

  localparam int cnt_w = $clog2(poly_n) + 1;

  logic             active_q;
  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] cnt_cur;
  mem_addr_t        addr_q;
  mem_addr_t        addr_cur;
  logic             wr_dv_q;
  mem_addr_t        wr_addr_q;
  coeff_t           wr_data_q;
  logic             done_q;
  coeff_t           cand;
  logic             take;
  logic             accept;
  logic             last;

  assign cand = ent_data_i[22:0];

  // start cycle already consumes a beat
  assign take     = ent_valid_i & ~ent_hold_o & (active_q | start_i);
  assign accept   = take & (cand < mldsa_q);
  assign cnt_cur  = start_i ? '0 : cnt_q;
  assign addr_cur = start_i ? dest_base_addr_i : addr_q;
  assign last     = accept & (cnt_cur == cnt_w'(poly_n - 1));

  // hold off the stream during the final write and done
  assign ent_hold_o = ~active_q & (wr_dv_q | done_q);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      addr_q   <= '0;
      wr_dv_q  <= 1'b0;
      done_q   <= 1'b0;
    end else if (zeroize_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      addr_q   <= '0;
      wr_dv_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      active_q <= (active_q | start_i) & ~last;
      cnt_q    <= cnt_cur + cnt_w'(accept);
      addr_q   <= addr_cur + mem_addr_t'(accept);
      wr_dv_q  <= accept;
      done_q   <= wr_dv_q & ~active_q;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_data_q <= cand;
      wr_addr_q <= addr_cur;
    end
  end

  assign mem_wr_o = '{dv: wr_dv_q, addr: wr_addr_q, data: wr_data_q};
  assign done_o   = done_q;

  a_accept_writes_below_q: assert property (@(posedge clk) disable iff (!rst_b)
    mem_wr_o.dv |-> (mem_wr_o.data < mldsa_q));

endmodule

// ==== design/sampler_ctrl_pkg.sv ====
// sampler control package: mode and state encodings and the structs between blocks
package sampler_ctrl_pkg;

  // sampling function selected for a run
  typedef enum logic [0:0] {
    REJ_SAMPLE     = 1'b0,
    SAMPLE_IN_BALL = 1'b1
  } sampler_mode_e;

  // sample-in-ball engine states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    WAIT_BEAT = 3'd1,
    READ_J    = 3'd2,
    WRITE_I   = 3'd3,
    WRITE_J   = 3'd4,
    DONE      = 3'd5
  } sib_state_e;

  // one coefficient write to the destination memory
  typedef struct packed {
    logic                          dv;
    sampler_field_pkg::mem_addr_t  addr;
    sampler_field_pkg::coeff_t     data;
  } coeff_wr_t;

  // NTT read of the sign memory
  typedef struct packed {
    logic                         en;
    sampler_field_pkg::sib_idx_t  addr;
  } sib_rd_req_t;

  // single access to the sign memory
  typedef struct packed {
    logic                          cs;
    logic                          we;
    sampler_field_pkg::sib_idx_t   addr;
    sampler_field_pkg::sib_code_t  wdata;
  } sib_mem_req_t;

endpackage

// ==== design/sampler_field_pkg.sv ====
// sampler field package: widths, modulus and sign codes of the sampled polynomial
package sampler_field_pkg;

  // coefficient count of one polynomial
  localparam int poly_n = 256;

  // one coefficient modulo q
  typedef logic [22:0] coeff_t;

  // ML-DSA modulus
  localparam coeff_t mldsa_q = 23'd8380417;

  // one random beat from the entropy stream
  typedef logic [23:0] ent_word_t;

  // destination memory address
  typedef logic [9:0] mem_addr_t;

  // sign memory index, one entry per coefficient
  typedef logic [7:0] sib_idx_t;

  // encoded sign of one coefficient
  typedef logic [1:0] sib_code_t;

  localparam sib_code_t sib_code_zero = 2'b00;
  localparam sib_code_t sib_code_pos  = 2'b01;
  // -1, decodes to q-1
  localparam sib_code_t sib_code_neg  = 2'b11;

endpackage

// ==== design/sampler_top.sv ====
// coefficient sampler top: steers the beat stream to the selected sampler and tracks the run
module sampler_top #(
  parameter int SIB_TAU = 39
) (
  input  logic                            clk,
  input  logic                            rst_b,
  input  logic                            zeroize_i,
  input  logic                            start_i,
  input  sampler_ctrl_pkg::sampler_mode_e mode_i,
  input  sampler_field_pkg::mem_addr_t    dest_base_addr_i,
  input  logic                            ent_valid_i,
  input  sampler_field_pkg::ent_word_t    ent_data_i,
  input  sampler_ctrl_pkg::sib_rd_req_t   ntt_rd_i,
  output logic                            ent_hold_o,
  output sampler_ctrl_pkg::coeff_wr_t     mem_wr_o,
  output sampler_field_pkg::coeff_t       ntt_rd_data_o,
  output logic                            busy_o,
  output logic                            done_o
);
  import sampler_field_pkg::*;
  import sampler_ctrl_pkg::*;

  logic         sib_sel;
  logic         rej_start, rej_valid, rej_hold, rej_done;
  logic         sib_start, sib_valid, sib_hold, sib_done;
  logic         sib_clear, eng_grant;
  sib_mem_req_t eng_req;
  sib_mem_req_t mem_req;
  sib_code_t    mem_rdata;
  logic         busy_q;

  assign sib_sel   = (mode_i == SAMPLE_IN_BALL);
  assign rej_start = start_i & ~sib_sel;
  assign sib_start = start_i & sib_sel;
  assign rej_valid = ent_valid_i & ~sib_sel;
  assign sib_valid = ent_valid_i & sib_sel;

  assign ent_hold_o = sib_sel ? sib_hold : rej_hold;
  assign done_o     = sib_sel ? sib_done : rej_done;

  // busy drops the cycle after done
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      busy_q <= 1'b0;
    end else if (zeroize_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= (busy_q | start_i) & ~done_o;
    end
  end

  assign busy_o = busy_q | start_i;

  rej_sampler u_rej_sampler (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .start_i          (rej_start),
    .ent_valid_i      (rej_valid),
    .ent_data_i       (ent_data_i),
    .dest_base_addr_i (dest_base_addr_i),
    .ent_hold_o       (rej_hold),
    .mem_wr_o         (mem_wr_o),
    .done_o           (rej_done)
  );

  sib_engine #(
    .SIB_TAU (SIB_TAU)
  ) u_sib_engine (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .start_i     (sib_start),
    .ent_valid_i (sib_valid),
    .ent_data_i  (ent_data_i),
    .grant_i     (eng_grant),
    .rd_code_i   (mem_rdata),
    .ent_hold_o  (sib_hold),
    .mem_req_o   (eng_req),
    .clear_o     (sib_clear),
    .done_o      (sib_done)
  );

  sib_mem_arbiter u_sib_mem_arbiter (
    .clk           (clk),
    .rst_b         (rst_b),
    .ntt_rd_i      (ntt_rd_i),
    .eng_req_i     (eng_req),
    .mem_rdata_i   (mem_rdata),
    .eng_grant_o   (eng_grant),
    .mem_req_o     (mem_req),
    .ntt_rd_data_o (ntt_rd_data_o)
  );

  // zeroize wipes the sign memory as well
  sib_mem u_sib_mem (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (sib_clear | zeroize_i),
    .req_i   (mem_req),
    .rdata_o (mem_rdata)
  );

  a_mode_known_while_busy: assert property (@(posedge clk) disable iff (!rst_b)
    busy_o |-> !$isunknown(mode_i));

endmodule

// ==== design/sib_engine.sv ====
// sample-in-ball engine: places TAU signed ones into the sign memory from the beat stream
module sib_engine #(
  parameter int SIB_TAU = 39
) (
  input  logic                            clk,
  input  logic                            rst_b,
  input  logic                            zeroize_i,
  input  logic                            start_i,
  input  logic                            ent_valid_i,
  input  sampler_field_pkg::ent_word_t    ent_data_i,
  input  logic                            grant_i,
  input  sampler_field_pkg::sib_code_t    rd_code_i,
  output logic                            ent_hold_o,
  output sampler_ctrl_pkg::sib_mem_req_t  mem_req_o,
  output logic                            clear_o,
  output logic                            done_o
);
  import sampler_field_pkg::*;
  import sampler_ctrl_pkg::*;

  localparam sib_idx_t first_idx = sib_idx_t'(poly_n - SIB_TAU);
  localparam sib_idx_t last_idx  = sib_idx_t'(poly_n - 1);

  sib_state_e state_q;
  sib_state_e state_d;
  sib_idx_t   i_q;
  sib_idx_t   j_q;
  sib_idx_t   beat_j;
  logic       sign_q;
  sib_code_t  code_q;
  logic       rd_pend_q;
  logic       take;
  logic       place;

  assign beat_j = ent_data_i[7:0];
  assign take   = ent_valid_i & ~ent_hold_o & (state_q == WAIT_BEAT);
  // j above i is rejected and costs the cycle
  assign place  = take & (beat_j <= i_q);

  assign ent_hold_o = start_i | (state_q inside {READ_J, WRITE_I, WRITE_J, DONE});
  assign clear_o    = start_i;
  assign done_o     = (state_q == DONE);

  always_comb begin
    state_d   = state_q;
    mem_req_o = '0;
    unique case (state_q)
      WAIT_BEAT: begin
        if (place) state_d = READ_J;
      end
      READ_J: begin
        mem_req_o.cs   = 1'b1;
        mem_req_o.addr = j_q;
        if (grant_i) state_d = WRITE_I;
      end
      WRITE_I: begin
        mem_req_o.cs    = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = i_q;
        // code at j arrives one cycle after the read, kept if the write waits
        mem_req_o.wdata = rd_pend_q ? rd_code_i : code_q;
        if (grant_i) state_d = WRITE_J;
      end
      WRITE_J: begin
        mem_req_o.cs    = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = j_q;
        mem_req_o.wdata = sign_q ? sib_code_neg : sib_code_pos;
        if (grant_i) state_d = (i_q == last_idx) ? DONE : WAIT_BEAT;
      end
      default: state_d = IDLE;
    endcase
    if (start_i) state_d = WAIT_BEAT;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q   <= IDLE;
      i_q       <= '0;
      rd_pend_q <= 1'b0;
    end else if (zeroize_i) begin
      state_q   <= IDLE;
      i_q       <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      rd_pend_q <= (state_q == READ_J) & grant_i;
      if (start_i) begin
        i_q <= first_idx;
      end else if ((state_q == WRITE_J) && grant_i && (i_q != last_idx)) begin
        i_q <= i_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (place) begin
      j_q    <= beat_j;
      sign_q <= ent_data_i[8];
    end
    if (rd_pend_q) code_q <= rd_code_i;
  end

  a_j_not_above_i: assert property (@(posedge clk) disable iff (!rst_b)
    (state_q inside {WRITE_I, WRITE_J}) |-> (j_q <= i_q));

endmodule

// ==== design/sib_mem.sv ====
// sign memory: 256 two-bit codes, registered read and single-cycle clear
module sib_mem (
  input  logic                            clk,
  input  logic                            rst_b,
  input  logic                            clear_i,
  input  sampler_ctrl_pkg::sib_mem_req_t  req_i,
  output sampler_field_pkg::sib_code_t    rdata_o
);
  import sampler_field_pkg::*;

  // flop array so the whole memory clears at once
  sib_code_t [poly_n-1:0] mem_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      mem_q <= '0;
    end else if (clear_i) begin
      mem_q <= '0;
    end else if (req_i.cs && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rdata_o <= sib_code_zero;
    end else if (req_i.cs && !req_i.we) begin
      rdata_o <= mem_q[req_i.addr];
    end
  end

endmodule

// ==== design/sib_mem_arbiter.sv ====
// sign memory arbiter that favors NTT reads over the engine and decodes NTT read codes
module sib_mem_arbiter (
  input  logic                            clk,
  input  logic                            rst_b,
  input  sampler_ctrl_pkg::sib_rd_req_t   ntt_rd_i,
  input  sampler_ctrl_pkg::sib_mem_req_t  eng_req_i,
  input  sampler_field_pkg::sib_code_t    mem_rdata_i,
  output logic                            eng_grant_o,
  output sampler_ctrl_pkg::sib_mem_req_t  mem_req_o,
  output sampler_field_pkg::coeff_t       ntt_rd_data_o
);
  import sampler_field_pkg::*;
  import sampler_ctrl_pkg::*;

  // returning read belongs to the NTT
  logic ntt_own_q;

  assign eng_grant_o = eng_req_i.cs & ~ntt_rd_i.en;

  always_comb begin
    if (ntt_rd_i.en) begin
      mem_req_o = '{cs: 1'b1, we: 1'b0, addr: ntt_rd_i.addr, wdata: sib_code_zero};
    end else begin
      mem_req_o = eng_req_i;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ntt_own_q <= 1'b0;
    end else begin
      ntt_own_q <= ntt_rd_i.en;
    end
  end

  always_comb begin
    ntt_rd_data_o = '0;
    if (ntt_own_q) begin
      unique case (mem_rdata_i)
        sib_code_pos: ntt_rd_data_o = coeff_t'(1);
        sib_code_neg: ntt_rd_data_o = coeff_t'(mldsa_q - 1);
        default:      ntt_rd_data_o = '0;
      endcase
    end
  end

  a_ntt_blocks_engine: assert property (@(posedge clk) disable iff (!rst_b)
    ntt_rd_i.en |-> (!eng_grant_o && mem_req_o.cs && !mem_req_o.we &&
                     (mem_req_o.addr == ntt_rd_i.addr)));

endmodule

// ==== sampler.f ====
+incdir+verif
design/sampler_field_pkg.sv
design/sampler_ctrl_pkg.sv
design/sib_mem.sv
design/sib_mem_arbiter.sv
design/sib_engine.sv
design/rej_sampler.sv
design/sampler_top.sv
verif/sampler_tb.sv

// ==== verif/sampler_tb_model.svh ====
// sampler reference model: expected coefficient writes and sign memory contents from the beats

localparam int model_q = 8380417;
localparam int model_n = 256;

// decoded coefficient expected in each sign memory entry
int sign_model [model_n];

// a candidate survives when its low 23 bits are below q
function automatic bit rej_keeps(input logic [23:0] beat);
  return int'(beat[22:0]) < model_q;
endfunction

function automatic void clear_sign_model();
  foreach (sign_model[k]) begin
    sign_model[k] = 0;
  end
endfunction

// one placement step at position i, returns 0 when j lies above i
function automatic bit sib_place(input logic [23:0] beat, input int i);
  int j;
  j = int'(beat[7:0]);
  if (j > i) begin
    return 1'b0;
  end
  sign_model[i] = sign_model[j];
  // bit 8 picks the sign of the new entry at j
  sign_model[j] = beat[8] ? model_q - 1 : 1;
  return 1'b1;
endfunction

// ==== verif/sampler_tb.sv ====
// coefficient sampler testbench with table-driven runs checked against a reference model
module sampler_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import sampler_field_pkg::*;
  import sampler_ctrl_pkg::*;

  localparam int tau            = 39;
  localparam int num_tests      = 6;
  localparam int timeout_cycles = num_tests * 2000;

  typedef struct packed {
    logic [8*12-1:0] name;
    sampler_mode_e   mode;
    mem_addr_t       base;
    logic            ntt_mix;
    logic            zeroize_mid;
  } test_row_t;

  localparam test_row_t tests [num_tests] = '{
    '{"rej_base0",   REJ_SAMPLE,     10'h000, 1'b0, 1'b0},
    '{"rej_base1a0", REJ_SAMPLE,     10'h1a0, 1'b0, 1'b0},
    '{"sib_plain",   SAMPLE_IN_BALL, 10'h000, 1'b0, 1'b0},
    '{"sib_ntt_mix", SAMPLE_IN_BALL, 10'h000, 1'b1, 1'b0},
    '{"rej_zeroize", REJ_SAMPLE,     10'h040, 1'b0, 1'b1},
    '{"rej_rerun",   REJ_SAMPLE,     10'h2c0, 1'b0, 1'b0}
  };

  logic          clk = 1'b0;
  logic          rst_b;
  logic          zeroize;
  logic          start;
  sampler_mode_e mode;
  mem_addr_t     dest_base_addr;
  logic          ent_valid;
  ent_word_t     ent_data;
  sib_rd_req_t   ntt_rd;
  logic          ent_hold;
  coeff_wr_t     mem_wr;
  coeff_t        ntt_rd_data;
  logic          busy;
  logic          done;

  integer seed        = 32'h605a_d5df;
  int     cycle_count = 0;
  string  test_name   = "reset";

  `include "sampler_tb_model.svh"

  sampler_top #(
    .SIB_TAU (tau)
  ) u_dut (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize),
    .start_i          (start),
    .mode_i           (mode),
    .dest_base_addr_i (dest_base_addr),
    .ent_valid_i      (ent_valid),
    .ent_data_i       (ent_data),
    .ntt_rd_i         (ntt_rd),
    .ent_hold_o       (ent_hold),
    .mem_wr_o         (mem_wr),
    .ntt_rd_data_o    (ntt_rd_data),
    .busy_o           (busy),
    .done_o           (done)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      stop_with_failure($sformatf("timeout: test %s did not finish within %0d cycles",
                                  test_name, timeout_cycles));
    end
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else stop_with_failure($sformatf("error %s %s: expected %0h, actual %0h",
                                       test_name, what, expected, actual));
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond)
      else stop_with_failure($sformatf("%s: %s", test_name, what));
  endtask

  function automatic ent_word_t next_beat();
    ent_word_t beat;
    beat = ent_word_t'($random(seed));
    // some candidates land just under 2^23 and mostly above q
    if (($random(seed) & 7) == 0) begin
      beat[22:0] = 23'h7f_ffff - 23'($random(seed) & 16'h1fff);
    end
    return beat;
  endfunction

  task automatic read_back_sign_memory();
    int nonzero = 0;
    for (int a = 0; a <= model_n; a++) begin
      @(posedge clk);
      #1;
      ntt_rd.en   = (a < model_n);
      ntt_rd.addr = sib_idx_t'(a);
      @(negedge clk);
      if (a > 0) begin
        check_value($sformatf("sign memory %0d", a - 1), sign_model[a - 1], ntt_rd_data);
        nonzero += int'(ntt_rd_data != '0);
      end
    end
    check_value("nonzero coefficients", tau, nonzero);
  endtask

  task automatic run_test(input test_row_t row);
    ent_word_t beat;
    logic      exp_dv    = 1'b0;
    coeff_t    exp_data  = '0;
    int        acc_count = 0;
    int        wr_count  = 0;
    int        last_wr   = -1;
    int        sib_i     = model_n - tau;
    int        cyc       = 0;
    logic      rd_pend   = 1'b0;
    logic      rd_exact  = 1'b0;
    int        rd_exp    = 0;
    logic      run_over  = 1'b0;

    test_name = $sformatf("%0s", row.name);
    clear_sign_model();
    beat = next_beat();
    @(posedge clk);
    #1;
    mode           = row.mode;
    dest_base_addr = row.base;
    start          = 1'b1;
    while (!run_over) begin
      ent_valid   = ($random(seed) & 3) != 0;
      ent_data    = beat;
      ntt_rd.en   = row.ntt_mix && ($random(seed) & 1);
      ntt_rd.addr = sib_idx_t'($random(seed));
      zeroize     = row.zeroize_mid && (cyc == 120);
      @(negedge clk);
      check_value("busy during run", 1, busy);
      if (row.mode == REJ_SAMPLE && acc_count < model_n) begin
        check_value("hold while sampling", 0, ent_hold);
      end
      check_value("write valid", exp_dv, mem_wr.dv);
      if (mem_wr.dv) begin
        check_value("write address", row.base + mem_addr_t'(wr_count), mem_wr.addr);
        check_value("write data", exp_data, mem_wr.data);
        wr_count++;
        last_wr = cyc;
      end
      if (rd_pend && rd_exact) begin
        check_value("ntt read in run", rd_exp, ntt_rd_data);
      end else if (rd_pend) begin
        check_true(ntt_rd_data inside {23'd0, 23'd1, 23'(model_q - 1)},
                   "ntt read in run returned a value that is not 0, 1 or q-1");
      end else begin
        check_value("ntt data without read", 0, ntt_rd_data);
      end
      // engine waiting for a beat means the sign memory is settled
      rd_pend  = ntt_rd.en;
      rd_exact = !ent_hold && !start;
      rd_exp   = sign_model[ntt_rd.addr];
      exp_dv   = 1'b0;
      if (ent_valid && !ent_hold && !zeroize) begin
        if (row.mode == REJ_SAMPLE && acc_count < model_n && rej_keeps(beat)) begin
          exp_dv   = 1'b1;
          exp_data = beat[22:0];
          acc_count++;
        end else if (row.mode == SAMPLE_IN_BALL && sib_i < model_n && sib_place(beat, sib_i)) begin
          sib_i++;
        end
        beat = next_beat();
      end
      run_over = done || zeroize;
      @(posedge clk);
      #1;
      start   = 1'b0;
      zeroize = 1'b0;
      cyc++;
    end
    if (row.zeroize_mid) begin
      // beats stay offered and nothing may come out
      repeat (6) begin
        ent_valid = 1'b1;
        @(negedge clk);
        check_value("busy after zeroize", 0, busy);
        check_value("write valid after zeroize", 0, mem_wr.dv);
        check_value("done after zeroize", 0, done);
        @(posedge clk);
        #1;
      end
    end else begin
      if (row.mode == REJ_SAMPLE) begin
        check_value("write count", model_n, wr_count);
        check_value("cycles from last write to done", 1, cyc - 1 - last_wr);
      end else begin
        check_value("placements", tau, sib_i - (model_n - tau));
      end
      ent_valid = 1'b0;
      ntt_rd.en = 1'b0;
      @(negedge clk);
      check_value("busy after done", 0, busy);
      check_value("done after its pulse", 0, done);
      check_value("write valid after done", 0, mem_wr.dv);
      if (row.mode == SAMPLE_IN_BALL) begin
        read_back_sign_memory();
      end
    end
    ent_valid = 1'b0;
  endtask

  initial begin
    rst_b          = 1'b0;
    zeroize        = 1'b0;
    start          = 1'b0;
    mode           = REJ_SAMPLE;
    dest_base_addr = '0;
    ent_valid      = 1'b0;
    ent_data       = '0;
    ntt_rd         = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_b = 1'b1;
    @(negedge clk);
    check_value("busy after reset", 0, busy);
    check_value("done after reset", 0, done);
    check_value("write valid after reset", 0, mem_wr.dv);
    check_value("hold after reset", 0, ent_hold);
    for (int t = 0; t < num_tests; t++) begin
      run_test(tests[t]);
    end
    $display("No errors");
    $finish;
  end

endmodule
